// File: flist.f
logic/sem_mon_pkg.sv
logic/sem_reg_pkg.sv
logic/sem_report_parser.sv
logic/far_capture.sv
logic/err_tally.sv
logic/cmd_queue.sv
logic/sem_monitor_top.sv
testbench/sem_monitor_properties.sv
testbench/sem_monitor_tb.sv

// File: logic/cmd_queue.sv
`default_nettype none
`timescale 1ns/1ps

module cmd_queue (
	input  wire logic                   CLK40,
	input  wire logic                   RST,
	input  wire logic                   jtag_take_i,    // JTAG takes the command path
	input  wire logic                   jtag_send_i,    // One-cycle send pulse
	input  wire sem_mon_pkg::cmd_byte_t jtag_cmd_i,
	input  wire logic                   con_take_i,     // Console takes the command path
	input  wire logic                   con_send_i,
	input  wire sem_mon_pkg::cmd_byte_t con_cmd_i,
	input  wire logic                   mon_rxread_i,   // Controller pops a byte
	output sem_mon_pkg::cmd_byte_t      mon_rxdata_o,   // Oldest byte, FWFT
	output logic                        mon_rxempty_o
);
	import sem_mon_pkg::*;

	cmd_src_t  src_q;
	cmd_byte_t mem [CMD_DEPTH];
	cmd_ptr_t  wr_ptr_q;
	cmd_ptr_t  rd_ptr_q;
	cmd_byte_t wr_data;
	logic      send;
	logic      empty;
	logic      full;
	logic      wr_en;
	logic      rd_en;

	////////////////////////////////////////
	// Source select
	////////////////////////////////////////

	// Console wins when both take at once
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			src_q <= SRC_JTAG;
		end else if (con_take_i) begin
			src_q <= SRC_CON;
		end else if (jtag_take_i) begin
			src_q <= SRC_JTAG;
		end
	end

	assign send    = (src_q == SRC_CON) ? con_send_i : jtag_send_i;  // Other source ignored
	assign wr_data = (src_q == SRC_CON) ? con_cmd_i  : jtag_cmd_i;

	////////////////////////////////////////
	// Circular buffer
	////////////////////////////////////////

	// Same address, wrap bits differ means full
	assign empty = (wr_ptr_q == rd_ptr_q);
	assign full  = (wr_ptr_q[CMD_ADDR_W] != rd_ptr_q[CMD_ADDR_W]) &&
		(wr_ptr_q[CMD_ADDR_W-1:0] == rd_ptr_q[CMD_ADDR_W-1:0]);

	assign wr_en = send && !full;               // Overflow bytes are lost
	assign rd_en = mon_rxread_i && !empty;      // Pop on empty ignored

	always_ff @(posedge CLK40) begin
		if (wr_en)
			mem[wr_ptr_q[CMD_ADDR_W-1:0]] <= wr_data;
	end

	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end else begin
			if (wr_en) wr_ptr_q <= wr_ptr_q + cmd_ptr_t'(1);
			if (rd_en) rd_ptr_q <= rd_ptr_q + cmd_ptr_t'(1);
		end
	end

	// Head of queue shown while not empty
	assign mon_rxdata_o  = mem[rd_ptr_q[CMD_ADDR_W-1:0]];
	assign mon_rxempty_o = empty;

endmodule

`default_nettype wire

// File: logic/err_tally.sv
`default_nettype none
`timescale 1ns/1ps

module err_tally (
	input  wire logic                     CLK40,
	input  wire logic                     RST,
	input  wire sem_mon_pkg::report_evt_t evt_i,        // sed and ded used here
	input  wire logic                     cnt_clear_i,  // Zero both counters
	input  wire logic                     ded_clear_i,  // Drop the sticky flag
	output sem_reg_pkg::err_counts_t      counts_o,     // {dbl, sngl}
	output logic                          dbl_err_o     // Sticky double error
);
	import sem_reg_pkg::*;

	err_counts_t counts_q;
	logic        dbl_err_q;

	////////////////////////////////////////
	// Error counters
	////////////////////////////////////////

	// Both wrap at 255, clear wins over a same-cycle event
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			counts_q <= '0;
		end else if (cnt_clear_i) begin
			counts_q <= '0;
		end else begin
			if (evt_i.sed)
				counts_q.sngl <= counts_q.sngl + err_cnt_t'(1);  // Single error report
			if (evt_i.ded)
				counts_q.dbl <= counts_q.dbl + err_cnt_t'(1);    // Double error report
		end
	end

	////////////////////////////////////////
	// Sticky double error flag
	////////////////////////////////////////
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			dbl_err_q <= 1'b0;
		end else if (ded_clear_i) begin
			dbl_err_q <= 1'b0;      // Host ack beats a new DED
		end else if (evt_i.ded) begin
			dbl_err_q <= 1'b1;
		end
	end

	// Counter clear leaves the flag alone, flag clear leaves the counts alone
	assign counts_o  = counts_q;
	assign dbl_err_o = dbl_err_q;

endmodule

`default_nettype wire

// File: logic/far_capture.sv
`default_nettype none
`timescale 1ns/1ps

module far_capture (
	input  wire logic                     CLK40,
	input  wire logic                     RST,
	input  wire sem_mon_pkg::mon_window_t window_i,     // Char window from parser
	input  wire sem_mon_pkg::report_evt_t evt_i,        // Load events used here
	input  wire logic                     ded_clear_i,  // Host clear of both addresses
	output sem_reg_pkg::far_t             far_pa_o,     // Physical frame address
	output sem_reg_pkg::far_t             far_la_o      // Linear frame address
);
	import sem_mon_pkg::*;
	import sem_reg_pkg::*;

	far_t conv_d;       // Digits as nibbles, combinational
	far_t conv_q;       // Captured with the load event
	logic load_pa_q;
	logic load_la_q;
	far_t far_pa_q;
	far_t far_la_q;

	// Upper case hex char to nibble, 'A' is 8'h41 so low nibble plus nine
	function automatic logic [3:0] hex_nibble(input mon_char_t c);
		return c[6] ? c[3:0] + 4'd9 : c[3:0];
	endfunction

	////////////////////////////////////////
	// Digit conversion
	////////////////////////////////////////
	always_comb begin
		for (int i = 0; i < HEX_DIGITS; i++) begin
			conv_d[i*4 +: 4] = hex_nibble(window_i[i*8 +: 8]);  // Newest char lowest
		end
	end

	always_ff @(posedge CLK40) begin
		if (evt_i.load_pa || evt_i.load_la)
			conv_q <= conv_d;
	end

	// Delay the loads to line up with conv_q
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			load_pa_q <= 1'b0;
			load_la_q <= 1'b0;
		end else begin
			load_pa_q <= evt_i.load_pa;
			load_la_q <= evt_i.load_la;
		end
	end

	////////////////////////////////////////
	// Address registers
	////////////////////////////////////////
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			far_pa_q <= '0;
			far_la_q <= '0;
		end else begin
			if (load_pa_q) far_pa_q <= conv_q;      // Load beats clear
			else if (ded_clear_i) far_pa_q <= '0;
			if (load_la_q) far_la_q <= conv_q;
			else if (ded_clear_i) far_la_q <= '0;
		end
	end

	assign far_pa_o = far_pa_q;
	assign far_la_o = far_la_q;

endmodule

`default_nettype wire

// File: logic/sem_mon_pkg.sv
`default_nettype none

package sem_mon_pkg;

	////////////////////////////////////////
	// Monitor text stream
	////////////////////////////////////////
	localparam int WINDOW_CHARS = 9;                    // Chars held for token search
	localparam int HEX_DIGITS   = 6;                    // Address digits per report
	localparam int TOKEN_CHARS  = 3;                    // Every token is three chars

	typedef logic [7:0]                mon_char_t;      // One ASCII char
	typedef logic [WINDOW_CHARS*8-1:0] mon_window_t;    // Newest char in low byte
	typedef logic [TOKEN_CHARS*8-1:0]  mon_token_t;

	localparam mon_window_t WINDOW_BLANK = {WINDOW_CHARS{" "}};

	// Report tokens seen in the window
	localparam mon_token_t TOK_SED = "SED";             // Tail of single error report
	localparam mon_token_t TOK_DED = "DED";             // Tail of double error report
	localparam mon_token_t TOK_PA  = "PA ";             // Head of physical address
	localparam mon_token_t TOK_LA  = "LA ";             // Head of linear address

	// One-cycle parser events
	typedef struct packed {
		logic sed;
		logic ded;
		logic load_pa;
		logic load_la;
	} report_evt_t;

	////////////////////////////////////////
	// Command queue toward the controller
	////////////////////////////////////////
	localparam int CMD_DEPTH  = 16;
	localparam int CMD_ADDR_W = $clog2(CMD_DEPTH);
	localparam int CMD_PTR_W  = CMD_ADDR_W + 1;         // Extra bit tells full from empty

	typedef logic [7:0]           cmd_byte_t;
	typedef logic [CMD_PTR_W-1:0] cmd_ptr_t;

	typedef enum logic {SRC_JTAG, SRC_CON} cmd_src_t;   // Who owns the command path

endpackage

`default_nettype wire

// File: logic/sem_monitor_top.sv
`default_nettype none
`timescale 1ns/1ps

module sem_monitor_top (
	input  wire logic                       CLK40,
	input  wire logic                       RST,
	// Monitor stream out of the controller
	input  wire sem_mon_pkg::mon_char_t     mon_txdata_i,
	input  wire logic                       mon_txwrite_i,
	// Controller flags
	input  wire sem_reg_pkg::core_status_t  core_status_i,
	input  wire logic                       crc_err_i,
	// JTAG register block
	input  wire logic                       jtag_take_i,
	input  wire logic                       jtag_send_i,
	input  wire sem_mon_pkg::cmd_byte_t     jtag_cmd_i,
	// Debug console
	input  wire logic                       con_take_i,
	input  wire logic                       con_send_i,
	input  wire sem_mon_pkg::cmd_byte_t     con_cmd_i,
	input  wire logic                       mon_rxread_i,
	input  wire logic                       cnt_clear_i,  // Zero error counters
	input  wire logic                       ded_clear_i,  // Clear flag and addresses
	output sem_reg_pkg::far_t               far_pa_o,
	output sem_reg_pkg::far_t               far_la_o,
	output sem_reg_pkg::err_counts_t        err_cnt_o,
	output sem_reg_pkg::sem_status_t        status_o,
	// Monitor receive port into the controller
	output sem_mon_pkg::cmd_byte_t          mon_rxdata_o,
	output logic                            mon_rxempty_o
);
	import sem_mon_pkg::*;

	mon_window_t window;
	report_evt_t evt;
	logic        dbl_err;

	////////////////////////////////////////
	// Report decode
	////////////////////////////////////////
	sem_report_parser sem_report_parser_i (
		.CLK40(CLK40), .RST(RST),
		.mon_txdata_i(mon_txdata_i), .mon_txwrite_i(mon_txwrite_i),
		.window_o(window), .evt_o(evt)
	);

	far_capture far_capture_i (
		.CLK40(CLK40), .RST(RST),
		.window_i(window), .evt_i(evt), .ded_clear_i(ded_clear_i),
		.far_pa_o(far_pa_o), .far_la_o(far_la_o)
	);

	err_tally err_tally_i (
		.CLK40(CLK40), .RST(RST),
		.evt_i(evt), .cnt_clear_i(cnt_clear_i), .ded_clear_i(ded_clear_i),
		.counts_o(err_cnt_o), .dbl_err_o(dbl_err)
	);

	////////////////////////////////////////
	// Commands to the controller
	////////////////////////////////////////
	cmd_queue cmd_queue_i (
		.CLK40(CLK40), .RST(RST),
		.jtag_take_i(jtag_take_i), .jtag_send_i(jtag_send_i), .jtag_cmd_i(jtag_cmd_i),
		.con_take_i(con_take_i), .con_send_i(con_send_i), .con_cmd_i(con_cmd_i),
		.mon_rxread_i(mon_rxread_i),
		.mon_rxdata_o(mon_rxdata_o), .mon_rxempty_o(mon_rxempty_o)
	);

	// Status word for the JTAG registers
	always_comb begin
		status_o         = '0;              // Pad and reserved bits stay zero
		status_o.core    = core_status_i;   // Bits 6..0
		status_o.crc_err = crc_err_i;       // Bit 8
		status_o.dbl_err = dbl_err;         // Bit 9
	end

endmodule

`default_nettype wire

// File: logic/sem_reg_pkg.sv
`default_nettype none

package sem_reg_pkg;

	////////////////////////////////////////
	// Host visible register widths
	////////////////////////////////////////
	localparam int FAR_W        = 24;   // Frame address
	localparam int ERR_CNT_W    = 8;    // Each error counter
	localparam int STATUS_PAD_W = 6;    // Unused top of status word

	typedef logic [FAR_W-1:0]     far_t;
	typedef logic [ERR_CNT_W-1:0] err_cnt_t;

	// Controller state flags, initialization at bit 0
	typedef struct packed {
		logic uncorrectable;    // Bit 6
		logic essential;
		logic injection;
		logic classification;
		logic correction;
		logic observation;
		logic initialization;   // Bit 0
	} core_status_t;

	////////////////////////////////////////
	// Status word, 16 bits
	////////////////////////////////////////
	typedef struct packed {
		logic [STATUS_PAD_W-1:0] pad;      // Always zero
		logic                    dbl_err;  // Bit 9, sticky
		logic                    crc_err;  // Bit 8
		logic                    rsvd;     // Bit 7, zero
		core_status_t            core;     // Bits 6..0
	} sem_status_t;

	// Error counters, double count in upper byte
	typedef struct packed {
		err_cnt_t dbl;
		err_cnt_t sngl;
	} err_counts_t;

endpackage

`default_nettype wire

// File: logic/sem_report_parser.sv
`default_nettype none
`timescale 1ns/1ps

module sem_report_parser (
	input  wire logic                   CLK40,
	input  wire logic                   RST,
	input  wire sem_mon_pkg::mon_char_t mon_txdata_i,   // Monitor byte from controller
	input  wire logic                   mon_txwrite_i,  // Byte valid strobe
	output sem_mon_pkg::mon_window_t    window_o,       // Last nine chars
	output sem_mon_pkg::report_evt_t    evt_o           // One-cycle token events
);
	import sem_mon_pkg::*;

	mon_window_t window_q;
	mon_token_t  head;      // Three oldest chars
	mon_token_t  tail;      // Three newest chars
	report_evt_t hit;       // Token present now
	report_evt_t hit_q;     // Token present last cycle

	////////////////////////////////////////
	// Character window
	////////////////////////////////////////

	// No back-pressure on the monitor stream, every strobed byte lands here
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			window_q <= WINDOW_BLANK;   // Spaces, matches no token
		end else if (mon_txwrite_i) begin
			// Shift up one char, new one in the low byte
			window_q <= {window_q[(WINDOW_CHARS-1)*8-1:0], mon_txdata_i};
		end
	end

	assign window_o = window_q;

	////////////////////////////////////////
	// Token match
	////////////////////////////////////////
	assign head = window_q[WINDOW_CHARS*8-1 -: TOKEN_CHARS*8];
	assign tail = window_q[TOKEN_CHARS*8-1:0];

	always_comb begin
		hit         = '0;
		hit.sed     = (tail == TOK_SED);    // Report ends with SED
		hit.ded     = (tail == TOK_DED);    // Report ends with DED
		// Address tokens sit HEX_DIGITS chars back, so all digits are in
		hit.load_pa = (head == TOK_PA);
		hit.load_la = (head == TOK_LA);
	end

	// Previous match state per token
	always_ff @(posedge CLK40 or posedge RST) begin
		if (RST) begin
			hit_q <= '0;
		end else begin
			hit_q <= hit;
		end
	end

	////////////////////////////////////////
	// Event pulses
	////////////////////////////////////////

	// Rising edge of each match
	// A token that lingers while idle cycles pass fires only once
	// Shifted away and back in again gives a new pulse
	assign evt_o = report_evt_t'(hit & ~hit_q);

endmodule

`default_nettype wire

// File: testbench/sem_cases.txt
# op then operands, counts in decimal and values in hex, _ stands for a space
# CHK pa la counts status checks registers, POP byte pops a command and checks it
CHK 000000 000000 0000 0000
MON PA_00A1F3
MON LA_1B0C2D
CHK 00a1f3 1b0c2d 0000 0000
MON PA_3C9E07
MON SED
MON SED
MON SED
MON DED
MON DED
CHK 3c9e07 1b0c2d 0203 0200
MON SED___
IDLE 12
REP 256 SED
CORE 55 1
CHK 3c9e07 1b0c2d 0204 0355
CNTCLR
MON SED
DEDCLR
CORE 2a 0
CHK 000000 000000 0001 002a
CON 11
JTAG 21
JTAG 22
POP 21
POP 22
EMPTY
TAKEC
JTAG 33
CON 44
POP 44
EMPTY
FILL 17 60
DRAIN 16 60
EMPTY

// File: testbench/sem_monitor_properties.sv
`default_nettype none
`timescale 1ns/1ps

module sem_monitor_properties (
	input wire logic                     CLK40,
	input wire logic                     RST,
	input wire sem_reg_pkg::err_counts_t err_cnt_i,
	input wire sem_reg_pkg::far_t        far_pa_i,
	input wire sem_reg_pkg::far_t        far_la_i,
	input wire sem_mon_pkg::report_evt_t evt_i,
	input wire logic                     cnt_clear_i,
	input wire logic                     ded_clear_i,
	input wire logic                     mon_rxempty_i
);
	import sem_reg_pkg::*;

	int fail_cnt = 0;   // Failed assertions so far

	// Same value or one up, 255 to 0 counts as one up
	function automatic logic step_ok(input err_cnt_t prev, input err_cnt_t cur);
		return (cur == prev) || (cur == err_cnt_t'(prev + 1'b1));
	endfunction

	count_step_a: assert property (@(posedge CLK40) disable iff (RST)
		!$past(cnt_clear_i) |-> step_ok($past(err_cnt_i.sngl), err_cnt_i.sngl)
			&& step_ok($past(err_cnt_i.dbl), err_cnt_i.dbl))
		else begin
			$error("Error count moved by more than one in a cycle");
			fail_cnt++;
		end

	empty_after_rst_a: assert property (@(posedge CLK40) $fell(RST) |-> mon_rxempty_i)
		else begin
			$error("Command queue not empty after reset");
			fail_cnt++;
		end

	////////////////////////////////////////
	// Address writes, load two edges back or a host clear
	////////////////////////////////////////
	pa_load_a: assert property (@(posedge CLK40) disable iff (RST)
		$changed(far_pa_i) |-> $past(evt_i.load_pa, 2) || $past(ded_clear_i))
		else begin
			$error("Physical frame address changed outside a load");
			fail_cnt++;
		end

	la_load_a: assert property (@(posedge CLK40) disable iff (RST)
		$changed(far_la_i) |-> $past(evt_i.load_la, 2) || $past(ded_clear_i))
		else begin
			$error("Linear frame address changed outside a load");
			fail_cnt++;
		end

endmodule

bind sem_monitor_top sem_monitor_properties sem_monitor_properties_i (
	.CLK40(CLK40), .RST(RST), .err_cnt_i(err_cnt_o),
	.far_pa_i(far_pa_o), .far_la_i(far_la_o), .evt_i(evt),
	.cnt_clear_i(cnt_clear_i), .ded_clear_i(ded_clear_i),
	.mon_rxempty_i(mon_rxempty_o)
);

`default_nettype wire

// File: testbench/sem_monitor_tb.sv
`default_nettype none
`timescale 1ns/1ps

module sem_monitor_tb;
	import sem_mon_pkg::*;
	import sem_reg_pkg::*;

	localparam int WAIT_LIMIT = 100;            // Cycles before a queue wait gives up

	logic         CLK40;
	logic         RST;
	mon_char_t    mon_txdata_i;
	logic         mon_txwrite_i;
	logic         crc_err_i;
	logic         mon_rxread_i;
	core_status_t core_status_i;
	logic         jtag_take_i;
	logic         jtag_send_i;
	cmd_byte_t    jtag_cmd_i;
	logic         con_take_i;
	logic         con_send_i;
	cmd_byte_t    con_cmd_i;
	cmd_byte_t    mon_rxdata_o;
	logic         cnt_clear_i;
	logic         ded_clear_i;
	logic         mon_rxempty_o;
	far_t         far_pa_o;
	far_t         far_la_o;
	err_counts_t  err_cnt_o;
	sem_status_t  status_o;
	integer       seed = 32'h909e11bd;
	int           checks = 0;
	int           value_errs = 0;
	int           other_errs = 0;

	sem_monitor_top sem_monitor_top_i (.*);

	initial begin
		CLK40 = 1'b0;
		forever #10 CLK40 = ~CLK40;            // 20 ns period
	end

	task automatic tick();
		@(posedge CLK40);
		#2;                                     // Drive just after the edge
	endtask

	////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////
	task automatic check_far(input string name, input far_t got, input far_t exp);
		checks++;
		if (got !== exp) begin
			$display("Fail %s: got %h expected %h", name, got, exp);
			value_errs++;
		end
	endtask

	task automatic check_counts(input err_counts_t got, input err_counts_t exp);
		checks++;
		if (got !== exp) begin
			$display("Fail err_cnt_o: got %h expected %h", got, exp);
			value_errs++;
		end
	endtask

	task automatic check_status(input sem_status_t got, input sem_status_t exp);
		checks++;
		if (got !== exp) begin
			$display("Fail status_o: got %h expected %h", got, exp);
			value_errs++;
		end
	endtask

	task automatic check_cmd(input cmd_byte_t got, input cmd_byte_t exp);
		checks++;
		if (got !== exp) begin
			$display("Fail mon_rxdata_o: got %h expected %h", got, exp);
			value_errs++;
		end
	endtask

	////////////////////////////////////////
	// Case file helpers
	////////////////////////////////////////

	// Drop the rest of a comment line
	task automatic skip_line(input int fd);
		int ch;
		ch = $fgetc(fd);
		while (ch != "\n" && ch != -1)
			ch = $fgetc(fd);
	endtask

	// Case line must carry all its operands
	task automatic expect_operands(input int got, input int want);
		if (got != want) begin
			$display("A case file line has too few operands");
			other_errs++;
		end
	endtask

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	// Right-justified text, underscore stands for a space
	task automatic send_text(input logic [255:0] text);
		mon_char_t c;
		int        gap;
		for (int i = 31; i >= 0; i--) begin
			c = text[i*8 +: 8];
			if (c != 8'h00) begin
				mon_txdata_i  = (c == "_") ? 8'h20 : c;
				mon_txwrite_i = 1'b1;
				tick();
				mon_txwrite_i = 1'b0;
				gap = $unsigned($random(seed)) % 4;   // Random idle gap
				repeat (gap) tick();
			end
		end
		repeat (3) tick();                      // Address load needs two idle edges
	endtask

	task automatic send_cmd(input logic from_con, input cmd_byte_t b);
		if (from_con) begin
			con_cmd_i  = b;
			con_send_i = 1'b1;
		end else begin
			jtag_cmd_i  = b;
			jtag_send_i = 1'b1;
		end
		tick();
		con_send_i  = 1'b0;
		jtag_send_i = 1'b0;
	endtask

	task automatic pop_expect(input cmd_byte_t exp);
		int n;
		n = 0;
		while (mon_rxempty_o && n < WAIT_LIMIT) begin
			tick();
			n++;
		end
		if (mon_rxempty_o) begin
			$display("Queue stayed empty while byte %h was expected", exp);
			other_errs++;
		end else begin
			check_cmd(mon_rxdata_o, exp);       // FWFT head
			mon_rxread_i = 1'b1;
			tick();
			mon_rxread_i = 1'b0;
		end
	endtask

	task automatic wait_empty();
		int n;
		n = 0;
		while (!mon_rxempty_o && n < WAIT_LIMIT) begin
			tick();
			n++;
		end
		if (!mon_rxempty_o) begin
			$display("Queue still holds bytes where it should be empty");
			other_errs++;
		end
	endtask

	////////////////////////////////////////
	// Case file runner
	////////////////////////////////////////
	initial begin
		int           fd;
		int           cnt;
		int           assert_errs;
		logic [255:0] op;
		logic [255:0] text;
		logic [23:0]  v0;
		logic [23:0]  v1;
		logic [23:0]  v2;
		logic [23:0]  v3;
		{mon_txdata_i, mon_txwrite_i, crc_err_i, mon_rxread_i} = '0;
		{jtag_take_i, jtag_send_i, jtag_cmd_i} = '0;
		{con_take_i, con_send_i, con_cmd_i} = '0;
		{cnt_clear_i, ded_clear_i} = '0;
		core_status_i = '0;
		RST = 1'b1;
		repeat (3) @(posedge CLK40);
		#2;
		RST = 1'b0;
		fd = $fopen("testbench/sem_cases.txt", "r");
		if (fd == 0) begin
			$display("Could not open the case file testbench/sem_cases.txt");
			other_errs++;
		end else begin
			while ($fscanf(fd, "%s", op) == 1) begin
				case (op)
					"#": skip_line(fd);         // Comment line
					"MON": begin
						expect_operands($fscanf(fd, "%s", text), 1);
						send_text(text);
					end
					"REP": begin
						expect_operands($fscanf(fd, "%d %s", cnt, text), 2);
						repeat (cnt) send_text(text);
					end
					"IDLE": begin
						expect_operands($fscanf(fd, "%d", cnt), 1);
						repeat (cnt) tick();
					end
					"CORE": begin
						expect_operands($fscanf(fd, "%h %h", v0, v1), 2);
						core_status_i = core_status_t'(v0[6:0]);
						crc_err_i     = v1[0];
						tick();                 // Let the status word settle
					end
					"CNTCLR", "DEDCLR": begin
						cnt_clear_i = (op == "CNTCLR");
						ded_clear_i = (op == "DEDCLR");
						tick();
						{cnt_clear_i, ded_clear_i} = '0;
					end
					"CHK": begin
						expect_operands($fscanf(fd, "%h %h %h %h", v0, v1, v2, v3), 4);
						check_far("far_pa_o", far_pa_o, far_t'(v0));
						check_far("far_la_o", far_la_o, far_t'(v1));
						check_counts(err_cnt_o, err_counts_t'(v2[15:0]));
						check_status(status_o, sem_status_t'(v3[15:0]));
					end
					"JTAG", "CON": begin
						expect_operands($fscanf(fd, "%h", v0), 1);
						send_cmd(op == "CON", cmd_byte_t'(v0));
					end
					"TAKEC": begin
						con_take_i = 1'b1;
						tick();
						con_take_i = 1'b0;
					end
					"FILL": begin
						expect_operands($fscanf(fd, "%d %h", cnt, v0), 2);
						for (int k = 0; k < cnt; k++) send_cmd(1'b1, cmd_byte_t'(v0 + k));
					end
					"DRAIN": begin
						expect_operands($fscanf(fd, "%d %h", cnt, v0), 2);
						for (int k = 0; k < cnt; k++) pop_expect(cmd_byte_t'(v0 + k));
					end
					"POP": begin
						expect_operands($fscanf(fd, "%h", v0), 1);
						pop_expect(cmd_byte_t'(v0));
					end
					"EMPTY": wait_empty();
					default: begin
						$display("Unknown operation in the case file");
						other_errs++;
					end
				endcase
			end
			$fclose(fd);
		end
		assert_errs = sem_monitor_top_i.sem_monitor_properties_i.fail_cnt;
		$display("Checks %0d, value errors %0d, other errors %0d, assertion errors %0d",
			checks, value_errs, other_errs, assert_errs);
		if (value_errs == 0 && other_errs == 0 && assert_errs == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
